//--- flashCommander.sv
// flash status and id commands
`timescale 1ns/1ps
`default_nettype none

module flashCommander (
	input wire logic SCK,
	input wire logic rst,
	// command request
	input wire logic cmdValid,
	output logic cmdReady,
	input wire flashPkg::flashOp cmdOp,
	// command result
	output logic resultValid,
	input wire logic resultReady,
	output logic [23:0] result, // status in the low byte
	// byte engine client
	output logic byteValid,
	input wire logic byteReady,
	output logic [7:0] txByte,
	output logic txLast,
	input wire logic rxValid,
	input wire logic [7:0] rxByte
);

	flashPkg::cmdState state;
	flashPkg::flashOp opReg; // only status or id
	logic [1:0] replyLeft; // dummy bytes still to send, minus one
	logic pending; // reply dummy in flight
	logic accept;
	logic rxReply;

	assign cmdReady = (state == flashPkg::cmdIdle);
	assign accept = byteValid & byteReady;
	assign rxReply = rxValid & pending; // opcode reply is dropped
	assign byteValid = (state == flashPkg::cmdOpcode) | ((state == flashPkg::cmdReply) & ~pending);
	assign txByte = (state == flashPkg::cmdOpcode) ? opReg : 8'h00;
	assign txLast = (state == flashPkg::cmdReply) & (replyLeft == 2'd0);

	always_ff @(posedge SCK) begin
		if (rst) begin
			state <= flashPkg::cmdIdle;
			pending <= 1'b0;
			resultValid <= 1'b0;
		end else begin
			case (state)
				flashPkg::cmdIdle:
					if (cmdValid) state <= flashPkg::cmdOpcode;
				flashPkg::cmdOpcode:
					if (accept) state <= flashPkg::cmdReply;
				flashPkg::cmdReply:
					if (accept && txLast) state <= flashPkg::cmdDone;
				flashPkg::cmdDone:
					if (resultValid && resultReady) state <= flashPkg::cmdIdle;
				default: state <= flashPkg::cmdIdle;
			endcase

			if (accept && (state == flashPkg::cmdReply)) pending <= 1'b1;
			else if (rxReply) pending <= 1'b0;

			if (rxReply && (state == flashPkg::cmdDone)) resultValid <= 1'b1; // final reply in
			else if (resultReady) resultValid <= 1'b0;
		end
	end

	// payload registers
	always_ff @(posedge SCK) begin
		if (cmdReady && cmdValid) begin
			// anything unknown becomes a status read
			if (cmdOp == flashPkg::opJedecId) begin
				opReg <= flashPkg::opJedecId;
				replyLeft <= 2'(flashPkg::jedecBytes - 1);
			end else begin
				opReg <= flashPkg::opReadStatus;
				replyLeft <= 2'd0;
			end
			result <= '0; // upper bytes stay zero for status
		end else begin
			if (accept && (state == flashPkg::cmdReply)) replyLeft <= replyLeft - 1'b1;
			if (rxReply) result <= {result[15:0], rxByte}; // first reply ends up on top
		end
	end

endmodule

`default_nettype wire

//--- flashModel.sv
// behavioral SPI flash
`timescale 1ns/1ps
`default_nettype none

module flashModel (
	input wire logic flashClk,
	input wire logic csn,
	input wire logic mosi,
	output logic miso,
	output logic badOpcode, // opcode outside 03h, 05h, 9Fh
	output logic badFrame, // byte count does not fit the opcode
	output int txnCount // csn frames closed so far
);

	logic [7:0] inByte, outByte, nextOut;
	logic [7:0] opcode;
	logic [23:0] addr;
	int bitCnt, byteCnt;
	int frameNo, seenFrame; // frames opened by csn, frames the shifter has caught up with

	initial begin
		miso = 1'b0;
		badOpcode = 1'b0;
		badFrame = 1'b0;
		txnCount = 0;
		inByte = 8'h00;
		outByte = 8'h00;
		nextOut = 8'h00;
		opcode = 8'h00;
		addr = '0;
		bitCnt = 0;
		byteCnt = 0;
		frameNo = 0;
		seenFrame = 0;
	end

	function automatic logic [7:0] memByte(input logic [23:0] a);
		return a[7:0] ^ a[15:8]; // low address byte xor middle byte
	endfunction

	always @(negedge csn) frameNo = frameNo + 1; // new transaction

	// mosi shifted in on the rising edge
	always @(posedge flashClk) begin
		if (seenFrame != frameNo) begin
			seenFrame = frameNo; // first clock of a frame
			bitCnt = 0;
			byteCnt = 0;
			nextOut = 8'h00;
		end
		inByte = {inByte[6:0], mosi};
		bitCnt = bitCnt + 1;
		if (bitCnt == 8) begin
			bitCnt = 0;
			byteCnt = byteCnt + 1;
			if (byteCnt == 1) begin
				opcode = inByte;
				if (inByte == flashPkg::opReadStatus) nextOut = 8'h5A;
				else if (inByte == flashPkg::opJedecId) nextOut = 8'hEF; // manufacturer
				else if (inByte != flashPkg::opRead) badOpcode = 1'b1;
			end else if (opcode == flashPkg::opRead) begin
				if (byteCnt <= 4) addr = {addr[15:0], inByte}; // address MSB first
				else addr = addr + 24'd1; // sequential read
				nextOut = (byteCnt >= 4) ? memByte(addr) : 8'h00;
			end else if (opcode == flashPkg::opJedecId) begin
				nextOut = (byteCnt == 2) ? 8'h40 : ((byteCnt == 3) ? 8'h15 : 8'h00);
			end
		end
	end

	// miso driven after the falling edge, first bit ready before the next rise
	always @(negedge flashClk) begin
		if (!csn) begin
			if (bitCnt == 0) outByte = nextOut; // byte boundary
			miso = outByte[7];
			outByte = {outByte[6:0], 1'b0};
		end
	end

	// frame closed, byte count must match the opcode
	always @(posedge csn) begin
		if (frameNo != 0) begin
			if (bitCnt != 0) badFrame = 1'b1; // partial byte
			else if (opcode == flashPkg::opRead && byteCnt < 5) badFrame = 1'b1;
			else if (opcode == flashPkg::opReadStatus && byteCnt != 2) badFrame = 1'b1;
			else if (opcode == flashPkg::opJedecId && byteCnt != 4) badFrame = 1'b1;
			txnCount = txnCount + 1;
		end
	end

endmodule

`default_nettype wire

//--- flashPkg.sv
// serial flash shared definitions
`default_nettype none

package flashPkg;

	// byte framing
	localparam int byteBits = 8; // bits per byte on the wire
	localparam int addrBytes = 3; // 24 bit address, MSB first
	localparam int jedecBytes = 3; // manufacturer, type, capacity

	// engine timing in SCK cycles
	localparam int releaseCycles = 2; // min csn high time between transactions
	localparam int cycleBits = $clog2(2 * byteBits); // flashClk runs at SCK/2
	localparam logic [cycleBits-1:0] lastCycle = cycleBits'(2 * byteBits - 1);
	localparam logic [cycleBits-1:0] releaseLast = cycleBits'(releaseCycles - 1);

	// opcodes understood by the flash, read-only subset
	typedef enum logic [7:0] {
		opRead = 8'h03, // read data, 24 bit address follows
		opReadStatus = 8'h05, // status register 1, one reply byte
		opJedecId = 8'h9F // jedec id, three reply bytes
	} flashOp;

	typedef enum logic [1:0] {
		engIdle, // waiting for a byte, csn may still be low
		engShift, // 16 SCK cycles per byte
		engRelease // csn high, deselect time
	} engineState;

	typedef enum logic [2:0] {
		rdIdle,
		rdCommand, // opcode byte
		rdAddress, // three address bytes
		rdData, // one dummy byte per data byte
		rdFinish // last data byte still on its way out
	} readerState;

	typedef enum logic [1:0] {
		cmdIdle,
		cmdOpcode,
		cmdReply, // dummy bytes clocking out the reply
		cmdDone // waiting for the last reply and the result handoff
	} cmdState;

endpackage

`default_nettype wire

//--- flashReader.sv
// flash data reader
`timescale 1ns/1ps
`default_nettype none

module flashReader (
	input wire logic SCK,
	input wire logic rst,
	// read request
	input wire logic rdValid,
	output logic rdReady,
	input wire logic [23:0] rdAddr,
	input wire logic [7:0] rdLen, // bytes minus one
	// data stream
	output logic dataValid,
	input wire logic dataReady,
	output logic [7:0] data,
	// byte engine client
	output logic byteValid,
	input wire logic byteReady,
	output logic [7:0] txByte,
	output logic txLast,
	input wire logic rxValid,
	input wire logic [7:0] rxByte
);

	flashPkg::readerState state;
	logic [23:0] addrReg; // shifted left as address bytes go out
	logic [1:0] addrIdx;
	logic [7:0] remaining; // dummy bytes still to send, minus one
	logic pending; // a data-phase dummy is in flight
	logic accept;

	assign rdReady = (state == flashPkg::rdIdle);
	assign accept = byteValid & byteReady;
	assign txLast = (state == flashPkg::rdData) & (remaining == 8'd0);

	// next dummy only once the output register is free
	assign byteValid = (state == flashPkg::rdCommand) | (state == flashPkg::rdAddress) |
		((state == flashPkg::rdData) & ~pending & ~dataValid);

	always_comb begin
		case (state)
			flashPkg::rdCommand: txByte = flashPkg::opRead;
			flashPkg::rdAddress: txByte = addrReg[23:16]; // MSB first
			default: txByte = 8'h00; // dummy, only clocks out data
		endcase
	end

	always_ff @(posedge SCK) begin
		if (rst) begin
			state <= flashPkg::rdIdle;
			addrIdx <= '0;
			pending <= 1'b0;
			dataValid <= 1'b0;
		end else begin
			case (state)
				flashPkg::rdIdle:
					if (rdValid) state <= flashPkg::rdCommand;
				flashPkg::rdCommand:
					if (accept) begin
						state <= flashPkg::rdAddress;
						addrIdx <= '0;
					end
				flashPkg::rdAddress:
					if (accept) begin
						addrIdx <= addrIdx + 1'b1;
						if (addrIdx == 2'(flashPkg::addrBytes - 1))
							state <= flashPkg::rdData;
					end
				flashPkg::rdData:
					if (accept && txLast) state <= flashPkg::rdFinish;
				flashPkg::rdFinish:
					if (!pending && !dataValid) state <= flashPkg::rdIdle; // last byte taken
				default: state <= flashPkg::rdIdle;
			endcase

			if (accept && (state == flashPkg::rdData)) pending <= 1'b1;
			else if (rxValid && pending) pending <= 1'b0; // command and address replies dropped

			if (rxValid && pending) dataValid <= 1'b1;
			else if (dataReady) dataValid <= 1'b0;
		end
	end

	// payload registers
	always_ff @(posedge SCK) begin
		if (rdReady && rdValid) begin
			addrReg <= rdAddr;
			remaining <= rdLen;
		end else begin
			if (accept && (state == flashPkg::rdAddress)) addrReg <= {addrReg[15:0], 8'h00};
			if (accept && (state == flashPkg::rdData)) remaining <= remaining - 1'b1;
		end
		if (rxValid && pending) data <= rxByte;
	end

endmodule

`default_nettype wire

//--- flashStim.txt
// columns: kind address length expected, all hex, length in bytes
// kind 1 read, 2 status, 3 jedec id, 4 read with status, 5 read with jedec id
1 000123 01 000000
1 0012F8 10 000000
2 000000 00 00005A
3 000000 00 EF4015
4 00A0FE 04 00005A
1 7F0080 03 000000
5 03FFFC 08 EF4015
2 000000 00 00005A

//--- flashSubsystem.sv
// serial flash read subsystem
`timescale 1ns/1ps
`default_nettype none

module flashSubsystem (
	input wire logic SCK,
	input wire logic rst,
	// read request and data stream
	input wire logic rdValid,
	output logic rdReady,
	input wire logic [23:0] rdAddr,
	input wire logic [7:0] rdLen,
	output logic dataValid,
	input wire logic dataReady,
	output logic [7:0] data,
	// command request and result
	input wire logic cmdValid,
	output logic cmdReady,
	input wire flashPkg::flashOp cmdOp,
	output logic resultValid,
	input wire logic resultReady,
	output logic [23:0] result,
	// flash pins
	output logic flashClk,
	output logic csn,
	output logic mosi,
	input wire logic miso
);

	// peer A, reader
	logic byteValidA, byteReadyA, txLastA, rxValidA;
	logic [7:0] txByteA, rxByteA;
	// peer B, commander
	logic byteValidB, byteReadyB, txLastB, rxValidB;
	logic [7:0] txByteB, rxByteB;
	// granted peer to engine
	logic engValid, engReady, engLast, engRxValid, engDone;
	logic [7:0] engByte, engRxByte;

	flashReader i_flashReader (
		.SCK(SCK), .rst(rst),
		.rdValid(rdValid), .rdReady(rdReady), .rdAddr(rdAddr), .rdLen(rdLen),
		.dataValid(dataValid), .dataReady(dataReady), .data(data),
		.byteValid(byteValidA), .byteReady(byteReadyA), .txByte(txByteA),
		.txLast(txLastA), .rxValid(rxValidA), .rxByte(rxByteA)
	);

	flashCommander i_flashCommander (
		.SCK(SCK), .rst(rst),
		.cmdValid(cmdValid), .cmdReady(cmdReady), .cmdOp(cmdOp),
		.resultValid(resultValid), .resultReady(resultReady), .result(result),
		.byteValid(byteValidB), .byteReady(byteReadyB), .txByte(txByteB),
		.txLast(txLastB), .rxValid(rxValidB), .rxByte(rxByteB)
	);

	spiArbiter i_spiArbiter (
		.SCK(SCK), .rst(rst),
		.engValid(engValid), .engReady(engReady), .engByte(engByte), .engLast(engLast),
		.engRxValid(engRxValid), .engRxByte(engRxByte), .engDone(engDone),
		.byteValidA(byteValidA), .byteReadyA(byteReadyA), .txByteA(txByteA),
		.txLastA(txLastA), .rxValidA(rxValidA), .rxByteA(rxByteA),
		.byteValidB(byteValidB), .byteReadyB(byteReadyB), .txByteB(txByteB),
		.txLastB(txLastB), .rxValidB(rxValidB), .rxByteB(rxByteB)
	);

	spiByteEngine i_spiByteEngine (
		.SCK(SCK), .rst(rst),
		.byteValid(engValid), .byteReady(engReady), .txByte(engByte), .txLast(engLast),
		.rxValid(engRxValid), .rxByte(engRxByte), .done(engDone),
		.flashClk(flashClk), .csn(csn), .mosi(mosi), .miso(miso)
	);

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# build and run the flash subsystem testbench with Verilator
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tbFlashSubsystem -f verilog.f \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/VtbFlashSubsystem > sim.log 2>&1
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

//--- spiArbiter.sv
// round robin byte engine arbiter
`timescale 1ns/1ps
`default_nettype none

module spiArbiter (
	input wire logic SCK,
	input wire logic rst,
	// engine side
	output logic engValid,
	input wire logic engReady,
	output logic [7:0] engByte,
	output logic engLast,
	input wire logic engRxValid,
	input wire logic [7:0] engRxByte,
	input wire logic engDone,
	// peer A
	input wire logic byteValidA,
	output logic byteReadyA,
	input wire logic [7:0] txByteA,
	input wire logic txLastA,
	output logic rxValidA,
	output logic [7:0] rxByteA,
	// peer B
	input wire logic byteValidB,
	output logic byteReadyB,
	input wire logic [7:0] txByteB,
	input wire logic txLastB,
	output logic rxValidB,
	output logic [7:0] rxByteB
);

	logic granted; // a transaction is locked to one peer
	logic lastB; // owner while granted, last winner otherwise
	logic pickB; // choice for a new grant
	logic selB; // peer B drives the engine this cycle

	// on a tie the peer that did not win last time goes first
	assign pickB = byteValidB & (~byteValidA | ~lastB);
	assign selB = granted ? lastB : pickB;

	assign engValid = selB ? byteValidB : byteValidA;
	assign engByte = selB ? txByteB : txByteA;
	assign engLast = selB ? txLastB : txLastA;

	assign byteReadyA = engReady & ~selB;
	assign byteReadyB = engReady & selB;
	assign rxValidA = engRxValid & granted & ~lastB; // only the owner sees replies
	assign rxValidB = engRxValid & granted & lastB;
	assign rxByteA = engRxByte;
	assign rxByteB = engRxByte;

	always_ff @(posedge SCK) begin
		if (rst) begin
			granted <= 1'b0;
			lastB <= 1'b1; // peer A wins the first tie
		end else if (engDone) begin
			granted <= 1'b0; // csn has been high long enough
		end else if (!granted && engValid && engReady) begin
			granted <= 1'b1;
			lastB <= pickB;
		end
	end

endmodule

`default_nettype wire

//--- spiByteEngine.sv
// SPI byte engine
`timescale 1ns/1ps
`default_nettype none

module spiByteEngine (
	input wire logic SCK,
	input wire logic rst,
	input wire logic byteValid,
	output logic byteReady,
	input wire logic [7:0] txByte,
	input wire logic txLast, // release csn after this byte
	output logic rxValid, // one cycle pulse per received byte
	output logic [7:0] rxByte,
	output logic done, // end of deselect time
	output logic flashClk,
	output logic csn,
	output logic mosi,
	input wire logic miso
);

	flashPkg::engineState state;
	logic [flashPkg::cycleBits-1:0] cnt; // half periods while shifting, deselect cycles
	logic [7:0] shiftReg; // tx out of the top, rx into the bottom
	logic misoBit; // miso captured on the rising flashClk edge
	logic last; // txLast of the byte in flight

	assign byteReady = (state == flashPkg::engIdle); // also between bytes of a transaction
	assign flashClk = (state == flashPkg::engShift) & cnt[0]; // mode 0, idles low
	assign mosi = (state == flashPkg::engShift) & shiftReg[7];
	assign rxByte = shiftReg; // valid while rxValid is high
	assign done = (state == flashPkg::engRelease) & (cnt == flashPkg::releaseLast);

	// control path
	always_ff @(posedge SCK) begin
		if (rst) begin
			state <= flashPkg::engIdle;
			cnt <= '0;
			csn <= 1'b1;
			rxValid <= 1'b0;
			last <= 1'b0;
		end else begin
			rxValid <= 1'b0; // pulse
			case (state)
				flashPkg::engIdle: begin
					if (byteValid) begin
						state <= flashPkg::engShift;
						cnt <= '0;
						csn <= 1'b0; // low from the next cycle on
						last <= txLast;
					end
				end
				flashPkg::engShift: begin
					cnt <= cnt + 1'b1;
					if (cnt == flashPkg::lastCycle) begin
						rxValid <= 1'b1; // 17 cycles after acceptance
						if (last) begin
							state <= flashPkg::engRelease;
							csn <= 1'b1;
							cnt <= '0;
						end else begin
							state <= flashPkg::engIdle; // csn stays low, wait for next byte
						end
					end
				end
				flashPkg::engRelease: begin
					cnt <= cnt + 1'b1;
					if (cnt == flashPkg::releaseLast)
						state <= flashPkg::engIdle;
				end
				default: state <= flashPkg::engIdle;
			endcase
		end
	end

	// data path, full duplex
	always_ff @(posedge SCK) begin
		if ((state == flashPkg::engIdle) && byteValid) begin
			shiftReg <= txByte;
		end else if (state == flashPkg::engShift) begin
			if (!cnt[0])
				misoBit <= miso; // flashClk about to rise
			else
				shiftReg <= {shiftReg[6:0], misoBit}; // falling edge, next mosi bit
		end
	end

endmodule

`default_nettype wire

//--- tbClock.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic SCK,
	output logic rst
);

	initial begin
		SCK = 1'b0;
		forever #20 SCK = ~SCK; // 40 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (8) @(posedge SCK); // 8 cycles in reset
		#1;
		rst = 1'b0; // released off the edge like every other input
	end

endmodule

`default_nettype wire

//--- tbFlashSubsystem.sv
// flash subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tbFlashSubsystem;

	logic SCK, rst;
	logic rdValid, rdReady, dataValid, dataReady;
	logic [23:0] rdAddr;
	logic [7:0] rdLen, data;
	logic cmdValid, cmdReady, resultValid, resultReady;
	flashPkg::flashOp cmdOp;
	logic [23:0] result;
	logic flashClk, csn, mosi, miso;
	logic badOpcode, badFrame; // raised by the flash model
	int txnCount; // csn frames seen by the flash model

	logic [23:0] stim [0:63]; // kind, address, length, expected per operation
	logic [31:0] rngState;
	int cycles = 0;
	int limit, nOps, nBytes, txnBefore, i;
	logic [23:0] kind, addr, len, expected;

	tbClock i_tbClock (.SCK(SCK), .rst(rst));

	flashSubsystem i_flashSubsystem (
		.SCK(SCK), .rst(rst),
		.rdValid(rdValid), .rdReady(rdReady), .rdAddr(rdAddr), .rdLen(rdLen),
		.dataValid(dataValid), .dataReady(dataReady), .data(data),
		.cmdValid(cmdValid), .cmdReady(cmdReady), .cmdOp(cmdOp),
		.resultValid(resultValid), .resultReady(resultReady), .result(result),
		.flashClk(flashClk), .csn(csn), .mosi(mosi), .miso(miso)
	);

	flashModel i_flashModel (
		.flashClk(flashClk), .csn(csn), .mosi(mosi), .miso(miso),
		.badOpcode(badOpcode), .badFrame(badFrame), .txnCount(txnCount)
	);

	task automatic stopRun();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, want);
			stopRun();
		end
	endtask

	function automatic logic nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223; // 32 bit LCG
		return rngState[16];
	endfunction

	function automatic logic [7:0] memByte(input logic [23:0] a);
		return a[7:0] ^ a[15:8]; // flash content rule
	endfunction

	task automatic doRead(input logic [23:0] start, input int count);
		logic [23:0] a;
		int got;
		a = start;
		got = 0;
		@(posedge SCK);
		#1;
		rdAddr = start;
		rdLen = 8'(count - 1); // bytes minus one
		rdValid = 1'b1;
		@(negedge SCK);
		while (!rdReady) @(negedge SCK);
		@(posedge SCK); // request taken
		#1;
		rdValid = 1'b0;
		while (got < count) begin
			dataReady = nextRandom(); // random back-pressure
			@(negedge SCK);
			if (dataValid && dataReady) begin
				check("data", 32'(data), 32'(memByte(a)));
				a = a + 24'd1;
				got = got + 1;
			end
			@(posedge SCK);
			#1;
		end
		dataReady = 1'b0;
	endtask

	task automatic doCommand(input flashPkg::flashOp op, input logic [23:0] want);
		@(posedge SCK);
		#1;
		cmdOp = op;
		cmdValid = 1'b1;
		@(negedge SCK);
		while (!cmdReady) @(negedge SCK);
		@(posedge SCK);
		#1;
		cmdValid = 1'b0;
		resultReady = 1'b1; // taken as soon as it shows
		@(negedge SCK);
		while (!resultValid) @(negedge SCK);
		check("result", 32'(result), 32'(want));
		@(posedge SCK);
		#1;
		resultReady = 0;
	endtask

	// run length guard
	always @(posedge SCK) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, an operation never completed", limit);
			stopRun();
		end else if (badOpcode) begin
			$display("flash model received an opcode it does not know");
			stopRun();
		end else if (badFrame) begin
			$display("flash model saw a transaction with the wrong number of bytes");
			stopRun();
		end
	end

	initial begin
		rdValid = 1'b0;
		rdAddr = '0;
		rdLen = '0;
		dataReady = 1'b0;
		cmdValid = 1'b0;
		cmdOp = flashPkg::opReadStatus;
		resultReady = 1'b0;
		rngState = 32'h62ca_20d2;
		for (i = 0; i < 64; i++) stim[i] = '0;
		$readmemh("flashStim.txt", stim);
		nOps = 0;
		nBytes = 0;
		while (nOps < 16 && stim[4 * nOps] != 0) begin // kind 0 ends the list
			kind = stim[4 * nOps];
			len = stim[4 * nOps + 2];
			if (kind == 1 || kind >= 4) nBytes = nBytes + int'(len) + 4; // opcode, address
			if (kind == 2 || kind == 4) nBytes = nBytes + 2;
			if (kind == 3 || kind == 5) nBytes = nBytes + 4;
			nOps = nOps + 1;
		end
		limit = 40 * nBytes + 200;
		if (nOps == 0) begin
			$display("no operations found in flashStim.txt");
			stopRun();
		end

		// idle bus after reset
		@(negedge rst);
		repeat (10) begin
			@(negedge SCK);
			check("csn", 32'(csn), 32'd1);
			check("flashClk", 32'(flashClk), 32'd0);
		end

		for (i = 0; i < nOps; i++) begin
			kind = stim[4 * i];
			addr = stim[4 * i + 1];
			len = stim[4 * i + 2];
			expected = stim[4 * i + 3];
			txnBefore = txnCount;
			case (kind)
				24'd1: doRead(addr, int'(len));
				24'd2: doCommand(flashPkg::opReadStatus, expected);
				24'd3: doCommand(flashPkg::opJedecId, expected);
				24'd4: fork // both raised in the same cycle
					doRead(addr, int'(len));
					doCommand(flashPkg::opReadStatus, expected);
				join
				24'd5: fork
					doRead(addr, int'(len));
					doCommand(flashPkg::opJedecId, expected);
				join
				default: begin
					$display("stimulus operation %0d has unknown kind %0h", i, kind);
					stopRun();
				end
			endcase
			@(negedge SCK);
			check("csn", 32'(csn), 32'd1); // deselected between operations
			check("flashClk", 32'(flashClk), 32'd0);
			check("txnCount", txnCount, txnBefore + ((kind >= 4) ? 2 : 1));
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
flashPkg.sv
spiByteEngine.sv
spiArbiter.sv
flashReader.sv
flashCommander.sv
flashSubsystem.sv
tbClock.sv
flashModel.sv
tbFlashSubsystem.sv
